// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_ecc_mem -Mdir obj_dir

output=$(./obj_dir/Vtb_ecc_mem 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'STATUS: PASS'; then
    exit 0
else
    exit 1
fi

// File: sources.f
verilog/ecc_pkg.sv
verilog/ecc_mem_if.sv
verilog/ecc_21_codec.sv
verilog/ecc_mem_array.sv
verilog/scrub_timer.sv
verilog/ecc_scrub_ctrl.sv
verilog/ecc_mem_top.sv
verif/tb_ecc_mem.sv

// File: verif/tb_ecc_mem.sv
`timescale 1ns/1ps

module tb_ecc_mem import ecc_pkg::*; ();

    localparam int MAX_ENTRIES = 160;
    localparam int RST_CYCLES  = 16;
    localparam int PLANTED     = 5;  // faults left for the scrubber.

    typedef enum logic [1:0] {
        OP_WR,
        OP_RD,
        OP_SWEEP
    } op_t;

    typedef struct packed {
        op_t       op;
        ecc_addr_t addr;
        ecc_data_t data;
        ecc_cw_t   flip;
        logic      byp;
        int        hold;      // cycles of rsp_ready low.
        ecc_data_t exp_data;
        logic      exp_sbit;
        logic      exp_dbit;
        corr_cnt_t exp_count;
    } entry_t;

    logic      clk;
    logic      rst_n;
    logic      req_valid;
    logic      req_ready;
    logic      req_write;
    ecc_addr_t req_addr;
    ecc_data_t req_wdata;
    ecc_cw_t   req_flip;
    logic      rsp_valid;
    logic      rsp_ready;
    ecc_data_t rsp_rdata;
    logic      rsp_sbit_err;
    logic      rsp_dbit_err;
    logic      bypass;
    corr_cnt_t corr_count;

    entry_t    tbl [MAX_ENTRIES];
    int        n_tbl;
    ecc_data_t model [MEM_DEPTH];  // last clean data written per entry.
    logic      table_ready;
    int        watchdog_cycles;
    ecc_data_t got_data;
    logic      got_sbit;
    logic      got_dbit;

    ecc_mem_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_write    (req_write),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .req_flip     (req_flip),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_rdata    (rsp_rdata),
        .rsp_sbit_err (rsp_sbit_err),
        .rsp_dbit_err (rsp_dbit_err),
        .bypass       (bypass),
        .corr_count   (corr_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic data_ok(input string name, input ecc_data_t got, input ecc_data_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic flag_ok(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL t=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic count_ok(input string name, input corr_cnt_t got, input corr_cnt_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic add_write(input ecc_addr_t a, input ecc_data_t d, input ecc_cw_t flip,
                             input logic byp);
        entry_t e;
        e      = '0;
        e.op   = OP_WR;
        e.addr = a;
        e.data = d;
        e.flip = flip;
        e.byp  = byp;
        tbl[n_tbl] = e;
        n_tbl++;
    endtask

    task automatic add_read(input ecc_addr_t a, input int hold, input logic byp,
                            input ecc_data_t exp_d, input logic sb, input logic db);
        entry_t e;
        e          = '0;
        e.op       = OP_RD;
        e.addr     = a;
        e.byp      = byp;
        e.hold     = hold;
        e.exp_data = exp_d;
        e.exp_sbit = sb;
        e.exp_dbit = db;
        tbl[n_tbl] = e;
        n_tbl++;
    endtask

    task automatic add_sweep(input corr_cnt_t cnt);
        entry_t e;
        e           = '0;
        e.op        = OP_SWEEP;
        e.exp_count = cnt;
        tbl[n_tbl]  = e;
        n_tbl++;
    endtask

    task automatic build_table;
        ecc_data_t d;
        ecc_addr_t a;
        ecc_cw_t   f;
        int        p;
        int        q;
        int        base;
        n_tbl = 0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            d = ecc_data_t'($urandom);
            model[i] = d;
            add_write(ecc_addr_t'(i), d, '0, 1'b0);
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            add_read(ecc_addr_t'(i), $urandom_range(0, 7), 1'b0, model[i], 1'b0, 1'b0);
        end
        for (p = 0; p < CW_W; p++) begin  // every codeword position, check bits too.
            a = ecc_addr_t'(p % MEM_DEPTH);
            d = ecc_data_t'($urandom);
            f = ecc_cw_t'(1) << p;
            add_write(a, d, f, 1'b0);
            add_read(a, 0, 1'b0, d, 1'b1, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            a = ecc_addr_t'($urandom_range(0, MEM_DEPTH - 1));
            d = ecc_data_t'($urandom);
            p = $urandom_range(0, CW_W - 1);
            q = p;
            while (q == p) begin
                q = $urandom_range(0, CW_W - 1);
            end
            f = (ecc_cw_t'(1) << p) | (ecc_cw_t'(1) << q);
            add_write(a, d, f, 1'b0);
            add_read(a, $urandom_range(0, 3), 1'b0, d ^ f[DATA_W-1:0], 1'b0, 1'b1);
        end
        for (int i = 0; i < 4; i++) begin
            a = ecc_addr_t'($urandom_range(0, MEM_DEPTH - 1));
            d = ecc_data_t'($urandom);
            f = ecc_cw_t'(1) << $urandom_range(0, DATA_W - 1);
            add_write(a, d, f, 1'b1);
            add_read(a, 0, 1'b1, d ^ f[DATA_W-1:0], 1'b0, 1'b0);
        end
        // clean image first, then faults the scrubber has to find.
        for (int i = 0; i < MEM_DEPTH; i++) begin
            d = ecc_data_t'($urandom);
            model[i] = d;
            add_write(ecc_addr_t'(i), d, '0, 1'b0);
        end
        base = $urandom_range(0, MEM_DEPTH - 1);
        for (int i = 0; i < PLANTED; i++) begin
            a = ecc_addr_t'((base + 3 * i) % MEM_DEPTH);
            p = $urandom_range(0, CW_W - 1);
            add_write(a, model[a], ecc_cw_t'(1) << p, 1'b0);
        end
        add_sweep(corr_cnt_t'(PLANTED));
        for (int i = 0; i < MEM_DEPTH; i++) begin
            add_read(ecc_addr_t'(i), 0, 1'b0, model[i], 1'b0, 1'b0);
        end
    endtask

    // returns on the accept edge, with req_valid still high.
    task automatic wait_accept;
        do begin
            @(negedge clk);
        end while (!req_ready);
        @(posedge clk);
    endtask

    task automatic write_word(input ecc_addr_t a, input ecc_data_t d, input ecc_cw_t flip);
        req_valid <= 1'b1;
        req_write <= 1'b1;
        req_addr  <= a;
        req_wdata <= d;
        req_flip  <= flip;
        wait_accept();
    endtask

    task automatic read_word(input ecc_addr_t a, input int hold, output ecc_data_t d,
                             output logic sb, output logic db);
        int waited;
        req_valid <= 1'b1;
        req_write <= 1'b0;
        req_addr  <= a;
        req_wdata <= '0;
        req_flip  <= '0;
        rsp_ready <= (hold == 0);
        wait_accept();
        req_valid <= 1'b0;
        do begin
            @(negedge clk);
        end while (!rsp_valid);
        d  = rsp_rdata;
        sb = rsp_sbit_err;
        db = rsp_dbit_err;
        flag_ok("req_ready", req_ready, 1'b0);
        waited = 0;
        while (waited < hold) begin
            @(posedge clk);
            waited++;
            if (waited == hold) begin
                rsp_ready <= 1'b1;
            end
            @(negedge clk);
            flag_ok("rsp_valid", rsp_valid, 1'b1);
            flag_ok("req_ready", req_ready, 1'b0);
            data_ok("rsp_rdata", rsp_rdata, d);
            flag_ok("rsp_sbit_err", rsp_sbit_err, sb);
            flag_ok("rsp_dbit_err", rsp_dbit_err, db);
        end
        @(posedge clk);  // response handshake.
    endtask

    task automatic sweep_idle(input corr_cnt_t exp_cnt);
        req_valid <= 1'b0;
        repeat (MEM_DEPTH * (SCRUB_INTERVAL + 4)) @(posedge clk);
        @(negedge clk);
        count_ok("corr_count", corr_count, exp_cnt);
        @(posedge clk);
    endtask

    initial begin
        wait (table_ready === 1'b1);
        watchdog_cycles = n_tbl * 20 + MEM_DEPTH * (SCRUB_INTERVAL + 4);
        wait (rst_n === 1'b1);
        repeat (watchdog_cycles) @(posedge clk);
        stop_run("timeout: the tests did not finish in the allowed number of cycles");
    end

    initial begin
        void'($urandom(40));
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req_write   = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        req_flip    = '0;
        rsp_ready   = 1'b0;
        bypass      = 1'b0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_tbl; i++) begin
            bypass <= tbl[i].byp;
            case (tbl[i].op)
                OP_WR: write_word(tbl[i].addr, tbl[i].data, tbl[i].flip);
                OP_RD: begin
                    read_word(tbl[i].addr, tbl[i].hold, got_data, got_sbit, got_dbit);
                    data_ok("rsp_rdata", got_data, tbl[i].exp_data);
                    flag_ok("rsp_sbit_err", got_sbit, tbl[i].exp_sbit);
                    flag_ok("rsp_dbit_err", got_dbit, tbl[i].exp_dbit);
                end
                OP_SWEEP: sweep_idle(tbl[i].exp_count);
                default: stop_run("unknown operation in the stimulus table");
            endcase
        end
        req_valid <= 1'b0;
        @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: verilog/ecc_21_codec.sv
`timescale 1ns/1ps

module ecc_21_codec import ecc_pkg::*; (
    input  ecc_data_t   enc_data,
    input  ecc_cw_t     dec_cw,
    input  logic        bypass,
    output ecc_parity_t enc_parity,
    output ecc_data_t   cor_data,
    output logic        sbit_err,
    output logic        dbit_err
);

    ecc_data_t   raw_data;
    ecc_parity_t raw_parity;
    ecc_parity_t syndrome;
    ecc_data_t   mask;
    logic        single;
    logic        double;

    function automatic ecc_parity_t calc_parity(input ecc_data_t d);
        ecc_parity_t p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[11]
             ^ d[13] ^ d[15] ^ d[17] ^ d[19];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^ d[12]
             ^ d[13] ^ d[16] ^ d[17] ^ d[20];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[14]
             ^ d[15] ^ d[16] ^ d[17];
        p[3] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[18]
             ^ d[19] ^ d[20];
        p[4] = d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17] ^ d[18]
             ^ d[19] ^ d[20];
        p[5] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11]
             ^ d[12] ^ d[14] ^ d[17] ^ d[18];
        return p;
    endfunction

    assign enc_parity = calc_parity(enc_data);

    assign raw_data   = dec_cw[DATA_W-1:0];
    assign raw_parity = dec_cw[CW_W-1:DATA_W];
    assign syndrome   = raw_parity ^ calc_parity(raw_data);

    always_comb begin
        mask   = '0;
        single = 1'b1;
        double = 1'b0;
        case (syndrome)
            6'b000000: single = 1'b0;
            6'b100011: mask = 21'h000001;
            6'b100101: mask = 21'h000002;
            6'b100110: mask = 21'h000004;
            6'b000111: mask = 21'h000008;
            6'b101001: mask = 21'h000010;
            6'b101010: mask = 21'h000020;
            6'b001011: mask = 21'h000040;
            6'b101100: mask = 21'h000080;
            6'b001101: mask = 21'h000100;
            6'b001110: mask = 21'h000200;
            6'b101111: mask = 21'h000400;
            6'b110001: mask = 21'h000800;
            6'b110010: mask = 21'h001000;
            6'b010011: mask = 21'h002000;
            6'b110100: mask = 21'h004000;
            6'b010101: mask = 21'h008000;
            6'b010110: mask = 21'h010000;
            6'b110111: mask = 21'h020000;
            6'b111000: mask = 21'h040000;
            6'b011001: mask = 21'h080000;
            6'b011010: mask = 21'h100000;
            // a flipped check bit leaves the data alone.
            6'b100000, 6'b010000, 6'b001000,
            6'b000100, 6'b000010, 6'b000001: mask = '0;
            default: begin
                single = 1'b0;
                double = 1'b1;  // uncorrectable.
            end
        endcase
    end

    assign cor_data = bypass ? raw_data : raw_data ^ mask;
    assign sbit_err = single & ~bypass;
    assign dbit_err = double & ~bypass;

endmodule

// File: verilog/ecc_mem_array.sv
`timescale 1ns/1ps

module ecc_mem_array import ecc_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    ecc_mem_if.mem mem
);

    ecc_cw_t store [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (mem.we) begin
            store[mem.addr] <= mem.wcw;
        end
    end

    // read port registers the addressed entry every edge.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem.rcw <= '0;
        end else begin
            mem.rcw <= store[mem.addr];  // old data on a same-edge write.
        end
    end

endmodule

// File: verilog/ecc_mem_if.sv
`timescale 1ns/1ps

interface ecc_mem_if import ecc_pkg::*; ();

    logic      we;
    ecc_addr_t addr;
    ecc_cw_t   wcw;   // codeword to store.
    ecc_cw_t   rcw;   // registered read codeword.

    modport ctrl (
        output we,
        output addr,
        output wcw,
        input  rcw
    );

    modport mem (
        input  we,
        input  addr,
        input  wcw,
        output rcw
    );

endinterface

// File: verilog/ecc_mem_top.sv
`timescale 1ns/1ps

module ecc_mem_top import ecc_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_valid,
    output logic      req_ready,
    input  logic      req_write,
    input  ecc_addr_t req_addr,
    input  ecc_data_t req_wdata,
    input  ecc_cw_t   req_flip,
    output logic      rsp_valid,
    input  logic      rsp_ready,
    output ecc_data_t rsp_rdata,
    output logic      rsp_sbit_err,
    output logic      rsp_dbit_err,
    input  logic      bypass,
    output corr_cnt_t corr_count
);

    logic        scrub_due;
    logic        scrub_done;
    ecc_addr_t   scrub_addr;
    ecc_data_t   enc_data;
    ecc_parity_t enc_parity;
    ecc_data_t   cor_data;
    logic        sbit_err;
    logic        dbit_err;

    ecc_mem_if u_mem_if ();

    ecc_21_codec u_codec (
        .enc_data   (enc_data),
        .dec_cw     (u_mem_if.rcw),
        .bypass     (bypass),
        .enc_parity (enc_parity),
        .cor_data   (cor_data),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    ecc_mem_array u_array (
        .clk   (clk),
        .rst_n (rst_n),
        .mem   (u_mem_if)
    );

    scrub_timer u_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .scrub_done (scrub_done),
        .scrub_due  (scrub_due),
        .scrub_addr (scrub_addr)
    );

    ecc_scrub_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_write    (req_write),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .req_flip     (req_flip),
        .req_ready    (req_ready),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_rdata    (rsp_rdata),
        .rsp_sbit_err (rsp_sbit_err),
        .rsp_dbit_err (rsp_dbit_err),
        .scrub_due    (scrub_due),
        .scrub_addr   (scrub_addr),
        .scrub_done   (scrub_done),
        .enc_data     (enc_data),
        .enc_parity   (enc_parity),
        .cor_data     (cor_data),
        .sbit_err     (sbit_err),
        .dbit_err     (dbit_err),
        .corr_count   (corr_count),
        .mem          (u_mem_if)
    );

endmodule

// File: verilog/ecc_pkg.sv
package ecc_pkg;

    localparam int DATA_W         = 21;
    localparam int PARITY_W       = 6;
    localparam int CW_W           = DATA_W + PARITY_W;
    localparam int MEM_DEPTH      = 16;
    localparam int ADDR_W         = 4;
    localparam int SCRUB_INTERVAL = 64;  // cycles between scrub visits.
    localparam int CORR_W         = 8;

    typedef logic [DATA_W-1:0]   ecc_data_t;
    typedef logic [PARITY_W-1:0] ecc_parity_t;
    typedef logic [CW_W-1:0]     ecc_cw_t;  // {parity, data}.
    typedef logic [ADDR_W-1:0]   ecc_addr_t;
    typedef logic [CORR_W-1:0]   corr_cnt_t;

    // controller states, user traffic first.
    typedef enum logic [2:0] {
        IDLE,
        USER_RD,
        RSP_HOLD,
        SCRUB_RD,
        SCRUB_WR
    } ctrl_state_t;

endpackage

// File: verilog/ecc_scrub_ctrl.sv
`timescale 1ns/1ps

module ecc_scrub_ctrl import ecc_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    input  logic        req_write,
    input  ecc_addr_t   req_addr,
    input  ecc_data_t   req_wdata,
    input  ecc_cw_t     req_flip,
    output logic        req_ready,
    output logic        rsp_valid,
    input  logic        rsp_ready,
    output ecc_data_t   rsp_rdata,
    output logic        rsp_sbit_err,
    output logic        rsp_dbit_err,
    input  logic        scrub_due,
    input  ecc_addr_t   scrub_addr,
    output logic        scrub_done,
    output ecc_data_t   enc_data,
    input  ecc_parity_t enc_parity,
    input  ecc_data_t   cor_data,
    input  logic        sbit_err,
    input  logic        dbit_err,
    output corr_cnt_t   corr_count,
    ecc_mem_if.ctrl     mem
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    ecc_addr_t   addr_q;
    ecc_cw_t     cw_enc;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req_valid) begin
                    state_nxt = req_write ? IDLE : USER_RD;
                end else if (scrub_due) begin
                    state_nxt = SCRUB_RD;
                end
            end
            USER_RD:  state_nxt = RSP_HOLD;
            RSP_HOLD: state_nxt = rsp_ready ? IDLE : RSP_HOLD;
            SCRUB_RD: state_nxt = sbit_err ? SCRUB_WR : IDLE;  // clean word, nothing to fix.
            SCRUB_WR: state_nxt = IDLE;
            default:  state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            addr_q <= req_valid ? req_addr : scrub_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            corr_count <= '0;
        end else if (state == SCRUB_WR && corr_count != '1) begin
            corr_count <= corr_count + 1'b1;  // saturates.
        end
    end

    // idle presents the scrub address so the read is ready in SCRUB_RD.
    assign mem.addr = (state == IDLE) ? (req_valid ? req_addr : scrub_addr) : addr_q;
    assign mem.we   = (state == IDLE && req_valid && req_write) || (state == SCRUB_WR);

    assign enc_data = (state == SCRUB_WR) ? cor_data : req_wdata;
    assign cw_enc   = {enc_parity, enc_data};
    assign mem.wcw  = (state == SCRUB_WR) ? cw_enc : cw_enc ^ req_flip;  // fault injection.

    assign scrub_done = (state == SCRUB_RD && !sbit_err) || (state == SCRUB_WR);

    assign req_ready    = (state == IDLE);
    assign rsp_valid    = (state == RSP_HOLD);
    assign rsp_rdata    = cor_data;  // stable while the address is held.
    assign rsp_sbit_err = sbit_err;
    assign rsp_dbit_err = dbit_err;

endmodule

// File: verilog/scrub_timer.sv
`timescale 1ns/1ps

module scrub_timer import ecc_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      scrub_done,
    output logic      scrub_due,
    output ecc_addr_t scrub_addr
);

    logic [$clog2(SCRUB_INTERVAL)-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt        <= '0;
            scrub_due  <= 1'b0;
            scrub_addr <= '0;
        end else if (scrub_done) begin
            cnt        <= '0;
            scrub_due  <= 1'b0;
            if (scrub_addr == ecc_addr_t'(MEM_DEPTH - 1)) begin
                scrub_addr <= '0;
            end else begin
                scrub_addr <= scrub_addr + 1'b1;
            end
        end else if (!scrub_due) begin
            if (cnt == ($clog2(SCRUB_INTERVAL))'(SCRUB_INTERVAL - 1)) begin
                scrub_due <= 1'b1;  // held until the visit ends.
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule
